/* hw/frontend_cfg_regs.sv */
`default_nettype none

`include "req_frontend_defs.svh"

module frontend_cfg_regs (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic cfg_we_i,
	input  wire logic [`CFG_ADDR_WIDTH-1:0] cfg_addr_i,
	input  wire logic [`CFG_DATA_WIDTH-1:0] cfg_wdata_i,
	output logic [`CFG_DATA_WIDTH-1:0] cfg_rdata_o,
	output req_frontend_pkg::cfg_t cfg_o
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cfg_o.arb_mode    <= 1'b0;   // round-robin
			cfg_o.afull_level <= `REQ_LEVEL_WIDTH'(`REQ_FIFO_DEPTH - 2);
		end else if (cfg_we_i) begin
			case (cfg_addr_i)
				`CFG_ADDR_WIDTH'(`CFG_ADDR_MODE):
					cfg_o.arb_mode <= cfg_wdata_i[0];
				`CFG_ADDR_WIDTH'(`CFG_ADDR_AFULL):
					cfg_o.afull_level <= cfg_wdata_i[`REQ_LEVEL_WIDTH-1:0];
				default: ;   // writes to unmapped addresses are ignored
			endcase
		end
	end

	// zero-filled readback
	always_comb begin
		cfg_rdata_o = '0;
		case (cfg_addr_i)
			`CFG_ADDR_WIDTH'(`CFG_ADDR_MODE):
				cfg_rdata_o[0] = cfg_o.arb_mode;
			`CFG_ADDR_WIDTH'(`CFG_ADDR_AFULL):
				cfg_rdata_o[`REQ_LEVEL_WIDTH-1:0] = cfg_o.afull_level;
			default: cfg_rdata_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* hw/index_extractor.sv */
`default_nettype none

`include "req_frontend_defs.svh"

module index_extractor (
	input  wire logic clk,
	input  wire logic rst_n,

	// AR channel
	input  wire logic [`REQ_ID_WIDTH-1:0] arid_i,
	input  wire logic [`REQ_ADDR_WIDTH-1:0] araddr_i,
	input  wire logic arvalid_i,
	output logic arready_o,

	// AW channel
	input  wire logic [`REQ_ID_WIDTH-1:0] awid_i,
	input  wire logic [`REQ_ADDR_WIDTH-1:0] awaddr_i,
	input  wire logic awvalid_i,
	output logic awready_o,

	// to the memory array
	output logic [`REQ_INDEX_WIDTH-1:0] index_o,

	// to the request queue
	input  wire logic fifo_afull_i,
	input  wire logic arb_mode_i,
	output logic fifo_we_o,
	output req_frontend_pkg::req_entry_t fifo_entry_o
);

	localparam logic [1:0] S_IDLE   = 2'd0;
	localparam logic [1:0] S_RGRANT = 2'd1;
	localparam logic [1:0] S_WGRANT = 2'd2;

	logic [1:0] state;
	logic prio_aw;        // set once AR was granted last
	logic pick_ar;
	logic pick_aw;
	logic grant_cycle;
	req_frontend_pkg::req_addr_u grant_addr;

	// read-first ignores the pointer, round-robin lets the loser of the last tie win
	always_comb begin
		pick_ar = arvalid_i && (!awvalid_i || arb_mode_i || !prio_aw);
		pick_aw = awvalid_i && !pick_ar;
	end

	assign grant_cycle = (state == S_RGRANT) || (state == S_WGRANT);
	assign arready_o = (state == S_RGRANT);
	assign awready_o = (state == S_WGRANT);

	always_comb begin
		grant_addr.raw = (state == S_WGRANT) ? awaddr_i : araddr_i;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			prio_aw   <= 1'b0;
			fifo_we_o <= 1'b0;
		end else begin
			fifo_we_o <= 1'b0;
			case (state)
				S_IDLE: begin
					if (!fifo_afull_i) begin
						if (pick_ar) begin
							state   <= S_RGRANT;
							prio_aw <= 1'b1;
						end else if (pick_aw) begin
							state   <= S_WGRANT;
							prio_aw <= 1'b0;
						end
					end
				end
				S_RGRANT, S_WGRANT: begin
					// request taken this cycle, entry goes out next
					state     <= S_IDLE;
					fifo_we_o <= 1'b1;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// capture address and ID while ready is high
	always_ff @(posedge clk) begin
		if (grant_cycle) begin
			fifo_entry_o.write <= (state == S_WGRANT);
			fifo_entry_o.id    <= (state == S_WGRANT) ? awid_i : arid_i;
			fifo_entry_o.addr  <= grant_addr;
			index_o            <= grant_addr.fields.index;   // set index for the array
		end
	end

endmodule

`default_nettype wire

/* hw/req_fifo.sv */
`default_nettype none

`include "req_frontend_defs.svh"

module req_fifo (
	input  wire logic clk,
	input  wire logic rst_n,

	// write side, from the extractor
	input  wire logic we_i,
	input  wire req_frontend_pkg::req_entry_t entry_i,

	// read side, to the consumer
	input  wire logic pop_i,
	output req_frontend_pkg::req_entry_t entry_o,
	output logic valid_o,

	// almost-full throttle
	input  wire logic [`REQ_LEVEL_WIDTH-1:0] afull_level_i,
	output logic afull_o
);

	localparam int DEPTH = `REQ_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	req_frontend_pkg::req_entry_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [`REQ_LEVEL_WIDTH-1:0] count;
	logic full;
	logic do_wr;
	logic do_rd;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		ptr_inc = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full    = (count == `REQ_LEVEL_WIDTH'(DEPTH));
	assign valid_o = (count != '0);
	assign do_wr   = we_i && !full;    // dropped when full
	assign do_rd   = pop_i && valid_o;

	// show-ahead head
	assign entry_o = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= entry_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			afull_o <= 1'b0;
		end else begin
			if (do_wr) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// compares the current count, so it trails a write by a cycle
			afull_o <= (count >= afull_level_i);
		end
	end

endmodule

`default_nettype wire

/* hw/req_frontend.sv */
`default_nettype none

`include "req_frontend_defs.svh"

module req_frontend (
	input  wire logic clk,
	input  wire logic rst_n,

	// AR channel
	input  wire logic [`REQ_ID_WIDTH-1:0] arid_i,
	input  wire logic [`REQ_ADDR_WIDTH-1:0] araddr_i,
	input  wire logic arvalid_i,
	output logic arready_o,

	// AW channel
	input  wire logic [`REQ_ID_WIDTH-1:0] awid_i,
	input  wire logic [`REQ_ADDR_WIDTH-1:0] awaddr_i,
	input  wire logic awvalid_i,
	output logic awready_o,

	// memory array index
	output logic [`REQ_INDEX_WIDTH-1:0] index_o,

	// consumer side of the request queue
	output req_frontend_pkg::req_entry_t entry_o,
	output logic entry_valid_o,
	input  wire logic pop_i,

	// config port
	input  wire logic cfg_we_i,
	input  wire logic [`CFG_ADDR_WIDTH-1:0] cfg_addr_i,
	input  wire logic [`CFG_DATA_WIDTH-1:0] cfg_wdata_i,
	output logic [`CFG_DATA_WIDTH-1:0] cfg_rdata_o
);

	req_frontend_pkg::cfg_t cfg;
	req_frontend_pkg::req_entry_t fifo_entry;
	logic fifo_we;
	logic fifo_afull;

	frontend_cfg_regs u_cfg (
		.clk         (clk),
		.rst_n       (rst_n),
		.cfg_we_i    (cfg_we_i),
		.cfg_addr_i  (cfg_addr_i),
		.cfg_wdata_i (cfg_wdata_i),
		.cfg_rdata_o (cfg_rdata_o),
		.cfg_o       (cfg)
	);

	index_extractor u_extractor (
		.clk          (clk),
		.rst_n        (rst_n),
		.arid_i       (arid_i),
		.araddr_i     (araddr_i),
		.arvalid_i    (arvalid_i),
		.arready_o    (arready_o),
		.awid_i       (awid_i),
		.awaddr_i     (awaddr_i),
		.awvalid_i    (awvalid_i),
		.awready_o    (awready_o),
		.index_o      (index_o),
		.fifo_afull_i (fifo_afull),
		.arb_mode_i   (cfg.arb_mode),
		.fifo_we_o    (fifo_we),
		.fifo_entry_o (fifo_entry)
	);

	req_fifo u_fifo (
		.clk           (clk),
		.rst_n         (rst_n),
		.we_i          (fifo_we),
		.entry_i       (fifo_entry),
		.pop_i         (pop_i),
		.entry_o       (entry_o),
		.valid_o       (entry_valid_o),
		.afull_level_i (cfg.afull_level),
		.afull_o       (fifo_afull)
	);

endmodule

`default_nettype wire

/* hw/req_frontend_defs.svh */
`ifndef REQ_FRONTEND_DEFS_SVH
`define REQ_FRONTEND_DEFS_SVH

// address word and request entry fields
`define REQ_ADDR_WIDTH   32
`define REQ_ID_WIDTH     8
`define REQ_INDEX_WIDTH  6
`define REQ_OFFSET_BITS  6

// request queue
`define REQ_FIFO_DEPTH   8
`define REQ_LEVEL_WIDTH  4   // holds 0..depth

// config register block
`define CFG_ADDR_WIDTH   2
`define CFG_DATA_WIDTH   8
`define CFG_ADDR_MODE    0
`define CFG_ADDR_AFULL   1

`endif

/* hw/req_frontend_pkg.sv */
`default_nettype none

`include "req_frontend_defs.svh"

package req_frontend_pkg;

	// tag sits above the set index, offset picks the byte within the line
	typedef struct packed {
		logic [`REQ_ADDR_WIDTH-`REQ_INDEX_WIDTH-`REQ_OFFSET_BITS-1:0] tag;
		logic [`REQ_INDEX_WIDTH-1:0] index;
		logic [`REQ_OFFSET_BITS-1:0] offset;
	} req_addr_fields_t;

	typedef union packed {
		logic [`REQ_ADDR_WIDTH-1:0] raw;
		req_addr_fields_t fields;
	} req_addr_u;

	// one queued request
	typedef struct packed {
		logic write;   // 1 for AW, 0 for AR
		logic [`REQ_ID_WIDTH-1:0] id;
		req_addr_u addr;
	} req_entry_t;

	typedef struct packed {
		logic arb_mode;   // 0 round-robin, 1 read-first
		logic [`REQ_LEVEL_WIDTH-1:0] afull_level;
	} cfg_t;

endpackage

`default_nettype wire

/* req_frontend.f */
+incdir+hw
hw/req_frontend_pkg.sv
hw/index_extractor.sv
hw/req_fifo.sv
hw/frontend_cfg_regs.sv
hw/req_frontend.sv
testbench/req_checker.sv
testbench/tb_req_frontend.sv

/* testbench/req_checker.sv */
`default_nettype none

`include "req_frontend_defs.svh"

module req_checker (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic [`REQ_ID_WIDTH-1:0] arid_i,
	input  wire logic [`REQ_ADDR_WIDTH-1:0] araddr_i,
	input  wire logic arvalid_i,
	input  wire logic arready_i,
	input  wire logic [`REQ_ID_WIDTH-1:0] awid_i,
	input  wire logic [`REQ_ADDR_WIDTH-1:0] awaddr_i,
	input  wire logic awvalid_i,
	input  wire logic awready_i,
	input  wire logic [`REQ_INDEX_WIDTH-1:0] index_i,
	input  wire req_frontend_pkg::req_entry_t entry_i,
	input  wire logic entry_valid_i,
	input  wire logic pop_i,
	input  wire logic cfg_we_i,
	input  wire logic [`CFG_ADDR_WIDTH-1:0] cfg_addr_i,
	input  wire logic [`CFG_DATA_WIDTH-1:0] cfg_wdata_i,
	input  wire logic [`CFG_DATA_WIDTH-1:0] cfg_rdata_i
);

	req_frontend_pkg::req_entry_t model_q[$];
	logic grant_q[$];          // 1 where AW is expected to win, in grant order
	logic mode_m;
	logic [`REQ_LEVEL_WIDTH-1:0] level_m;
	logic idx_pend = 1'b0;
	logic [`REQ_INDEX_WIDTH-1:0] idx_exp;
	logic rst_low_prev = 1'b0;
	logic [`CFG_DATA_WIDTH-1:0] rd_exp;
	int mismatch_count = 0;
	int other_count = 0;

	task automatic report_mismatch(input string name, input logic [63:0] exp_v,
			input logic [63:0] act_v);
		$display("mismatch at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
		mismatch_count++;
	endtask

	task automatic expect_grant(input logic is_write);
		grant_q.push_back(is_write);
	endtask

	task automatic final_check();
		if (model_q.size() != 0) begin
			$display("at %0t: %0d accepted requests were never popped", $time, model_q.size());
			other_count++;
		end
	endtask

	task automatic take_request(input logic wr, input logic [`REQ_ID_WIDTH-1:0] id,
			input logic [`REQ_ADDR_WIDTH-1:0] addr);
		req_frontend_pkg::req_entry_t e;
		logic exp_wr;
		e.write = wr;
		e.id = id;
		e.addr.raw = addr;
		if (grant_q.size() != 0) begin
			exp_wr = grant_q.pop_front();
			if (exp_wr != wr)
				report_mismatch("grant channel (1 = AW)", 64'(exp_wr), 64'(wr));
		end
		model_q.push_back(e);
		if (model_q.size() > int'(level_m) + 1) begin
			$display("at %0t: %0d requests queued, more than almost-full level %0d allows",
				$time, model_q.size(), level_m);
			other_count++;
		end
		idx_exp = addr[`REQ_OFFSET_BITS +: `REQ_INDEX_WIDTH];   // index sits above the offset
		idx_pend = 1'b1;
	endtask

	// sampled mid-cycle, so every handshake seen here completes on the next rising edge
	always @(negedge clk) begin
		if (!rst_n) begin
			if (rst_low_prev) begin
				if (arready_i !== 1'b0)
					report_mismatch("arready_o in reset", 64'(0), 64'(arready_i));
				if (awready_i !== 1'b0)
					report_mismatch("awready_o in reset", 64'(0), 64'(awready_i));
				if (entry_valid_i !== 1'b0)
					report_mismatch("entry_valid_o in reset", 64'(0), 64'(entry_valid_i));
			end
			model_q.delete();
			grant_q.delete();
			idx_pend = 1'b0;
			mode_m = 1'b0;
			level_m = `REQ_LEVEL_WIDTH'(`REQ_FIFO_DEPTH - 2);
			rst_low_prev = 1'b1;
		end else begin
			rst_low_prev = 1'b0;
			if (idx_pend) begin
				if (index_i !== idx_exp)
					report_mismatch("index_o", 64'(idx_exp), 64'(index_i));
				idx_pend = 1'b0;
			end
			if (arvalid_i && arready_i)
				take_request(1'b0, arid_i, araddr_i);
			if (awvalid_i && awready_i)
				take_request(1'b1, awid_i, awaddr_i);
			if (pop_i && entry_valid_i) begin
				if (model_q.size() == 0) begin
					$display("at %0t: pop of an entry that was never accepted", $time);
					other_count++;
				end else if (entry_i !== model_q[0]) begin
					report_mismatch("entry_o", 64'(model_q[0]), 64'(entry_i));
					void'(model_q.pop_front());
				end else begin
					void'(model_q.pop_front());
				end
			end
			if (cfg_we_i) begin
				if (cfg_addr_i == `CFG_ADDR_WIDTH'(`CFG_ADDR_MODE))
					mode_m = cfg_wdata_i[0];
				else if (cfg_addr_i == `CFG_ADDR_WIDTH'(`CFG_ADDR_AFULL))
					level_m = cfg_wdata_i[`REQ_LEVEL_WIDTH-1:0];
			end else begin
				rd_exp = '0;
				if (cfg_addr_i == `CFG_ADDR_WIDTH'(`CFG_ADDR_MODE))
					rd_exp[0] = mode_m;
				else if (cfg_addr_i == `CFG_ADDR_WIDTH'(`CFG_ADDR_AFULL))
					rd_exp[`REQ_LEVEL_WIDTH-1:0] = level_m;
				if (cfg_rdata_i !== rd_exp)
					report_mismatch("cfg_rdata_o", 64'(rd_exp), 64'(cfg_rdata_i));
			end
		end
	end

endmodule

`default_nettype wire

/* testbench/tb_req_frontend.sv */
`default_nettype none

`include "req_frontend_defs.svh"

module tb_req_frontend;

	typedef struct packed {
		logic cfg_we;
		logic [1:0] cfg_addr;
		logic [7:0] cfg_wdata;
		logic ar_v;
		logic [7:0] ar_id;
		logic [31:0] ar_addr;
		logic aw_v;
		logic [7:0] aw_id;
		logic [31:0] aw_addr;
		logic aw_first;      // expected winner when both are valid
		logic rnd;           // addresses come from the LFSR
		logic [7:0] pop_hold;
	} row_t;

	localparam int NUM_ROWS = 14;
	localparam int WAIT_LIMIT = 200;

	logic clk = 1'b0;
	logic rst_n;
	logic [`REQ_ID_WIDTH-1:0] arid_i, awid_i;
	logic [`REQ_ADDR_WIDTH-1:0] araddr_i, awaddr_i;
	logic arvalid_i, awvalid_i, arready_o, awready_o;
	logic [`REQ_INDEX_WIDTH-1:0] index_o;
	req_frontend_pkg::req_entry_t entry_o;
	logic entry_valid_o;
	logic pop_i;
	logic cfg_we_i;
	logic [`CFG_ADDR_WIDTH-1:0] cfg_addr_i;
	logic [`CFG_DATA_WIDTH-1:0] cfg_wdata_i, cfg_rdata_o;

	row_t rows [NUM_ROWS];
	logic [31:0] lfsr_state = 32'h9ec6;
	int cycle_cnt = 0;
	int pop_hold_until = 0;
	int timeouts = 0;
	int total;

	req_frontend req_frontend_i (.*);

	req_checker req_checker_i (
		.clk(clk), .rst_n(rst_n),
		.arid_i(arid_i), .araddr_i(araddr_i), .arvalid_i(arvalid_i), .arready_i(arready_o),
		.awid_i(awid_i), .awaddr_i(awaddr_i), .awvalid_i(awvalid_i), .awready_i(awready_o),
		.index_i(index_o), .entry_i(entry_o), .entry_valid_i(entry_valid_o), .pop_i(pop_i),
		.cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i), .cfg_wdata_i(cfg_wdata_i),
		.cfg_rdata_i(cfg_rdata_o)
	);

	always #10 clk = ~clk;

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	// consumer pops whenever the head is valid and it is not held off
	always @(posedge clk) begin
		#2;
		pop_i = rst_n && entry_valid_o && (cycle_cnt >= pop_hold_until);
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	function automatic row_t make_row(input logic cw, input logic [1:0] ca, input logic [7:0] cd,
			input logic arv, input logic [7:0] arid, input logic [31:0] ara,
			input logic awv, input logic [7:0] awid, input logic [31:0] awa,
			input logic awf, input logic rnd, input logic [7:0] hold);
		make_row = '{cw, ca, cd, arv, arid, ara, awv, awid, awa, awf, rnd, hold};
	endfunction

	task automatic write_cfg(input logic [1:0] addr, input logic [7:0] data);
		@(posedge clk);
		#2;
		cfg_we_i = 1'b1;
		cfg_addr_i = addr;
		cfg_wdata_i = data;
		@(posedge clk);
		#2;
		cfg_we_i = 1'b0;
	endtask

	task automatic wait_handshakes();
		logic ar_hs;
		logic aw_hs;
		int n;
		n = 0;
		while ((arvalid_i || awvalid_i) && n < WAIT_LIMIT) begin
			@(negedge clk);
			ar_hs = arvalid_i && arready_o;
			aw_hs = awvalid_i && awready_o;
			@(posedge clk);
			#2;
			if (ar_hs)
				arvalid_i = 1'b0;
			if (aw_hs)
				awvalid_i = 1'b0;
			n++;
		end
		if (arvalid_i || awvalid_i) begin
			$display("at %0t: request was not accepted within %0d cycles", $time, WAIT_LIMIT);
			timeouts++;
			arvalid_i = 1'b0;
			awvalid_i = 1'b0;
		end
	endtask

	task automatic apply_row(input row_t r);
		logic [31:0] a;
		@(negedge clk);
		if (cycle_cnt + r.pop_hold > pop_hold_until)
			pop_hold_until = cycle_cnt + r.pop_hold;   // a later row never shortens a hold
		if (r.cfg_we)
			write_cfg(r.cfg_addr, r.cfg_wdata);
		if (r.rnd) begin
			rand_bits(32, a);
			r.ar_addr = a;
			rand_bits(32, a);
			r.aw_addr = a;
		end
		if (r.ar_v && r.aw_v) begin
			req_checker_i.expect_grant(r.aw_first);
			req_checker_i.expect_grant(!r.aw_first);
		end else if (r.ar_v || r.aw_v) begin
			req_checker_i.expect_grant(r.aw_v);
		end
		@(posedge clk);
		#2;
		arid_i = r.ar_id;
		araddr_i = r.ar_addr;
		arvalid_i = r.ar_v;
		awid_i = r.aw_id;
		awaddr_i = r.aw_addr;
		awvalid_i = r.aw_v;
		wait_handshakes();
	endtask

	initial begin
		int n;
		rst_n = 1'b0;
		arid_i = '0;
		araddr_i = '0;
		arvalid_i = 1'b0;
		awid_i = '0;
		awaddr_i = '0;
		awvalid_i = 1'b0;
		pop_i = 1'b0;
		cfg_we_i = 1'b0;
		cfg_addr_i = '0;
		cfg_wdata_i = '0;

		rows[0]  = make_row(0, 0, 0, 1, 8'h11, 32'h0000_1a40, 0, 0, 0, 0, 0, 0);
		rows[1]  = make_row(0, 0, 0, 0, 0, 0, 1, 8'h22, 32'h8000_0fc0, 0, 0, 0);
		rows[2]  = make_row(0, 0, 0, 1, 8'h31, 32'h0000_2044, 1, 8'h32, 32'h0000_3088, 0, 0, 0);
		rows[3]  = make_row(0, 0, 0, 1, 8'h41, 0, 1, 8'h42, 0, 0, 1, 0);
		rows[4]  = make_row(0, 0, 0, 1, 8'h51, 32'h1234_5678, 0, 0, 0, 0, 0, 0);
		rows[5]  = make_row(1, 0, 1, 1, 8'h61, 32'h0000_0100, 1, 8'h62, 32'h0000_0200, 0, 0, 0);
		rows[6]  = make_row(0, 0, 0, 1, 8'h71, 0, 0, 0, 0, 0, 1, 0);
		rows[7]  = make_row(0, 0, 0, 1, 8'h81, 32'hffff_ffc0, 1, 8'h82, 32'h0000_0fff, 0, 0, 0);
		rows[8]  = make_row(1, 0, 0, 1, 8'h91, 32'h0000_0a80, 0, 0, 0, 0, 0, 0);
		rows[9]  = make_row(0, 0, 0, 1, 8'ha1, 32'h0000_0b00, 1, 8'ha2, 32'h0000_0c40, 1, 0, 0);
		// pops held off against a low almost-full level to build back-pressure
		rows[10] = make_row(1, 1, 3, 1, 8'hb1, 0, 1, 8'hb2, 0, 1, 1, 40);
		rows[11] = make_row(0, 0, 0, 1, 8'hc1, 0, 1, 8'hc2, 0, 1, 1, 0);
		rows[12] = make_row(0, 0, 0, 1, 8'hd1, 0, 1, 8'hd2, 0, 1, 1, 0);
		rows[13] = make_row(1, 1, 5, 0, 0, 0, 1, 8'he1, 0, 0, 1, 0);

		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;

		for (int i = 0; i < NUM_ROWS; i++)
			apply_row(rows[i]);

		// config is changed before a reset in the middle of traffic
		write_cfg(2'(`CFG_ADDR_MODE), 8'h01);
		@(posedge clk);
		#2;
		arid_i = 8'hf1;
		awid_i = 8'hf2;
		arvalid_i = 1'b1;
		awvalid_i = 1'b1;
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b0;
		arvalid_i = 1'b0;
		awvalid_i = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		cfg_addr_i = 2'(`CFG_ADDR_AFULL);   // readback of both registers after reset
		@(posedge clk);
		#2;
		cfg_addr_i = 2'(`CFG_ADDR_MODE);
		// a tie right after reset goes to AR
		apply_row(make_row(0, 0, 0, 1, 8'hf3, 32'h0000_5fc0,
			1, 8'hf4, 32'h0000_7a80, 0, 0, 0));

		@(posedge clk);   // last entry is at the head two cycles after its ready
		#2;
		n = 0;
		while (entry_valid_o && n < WAIT_LIMIT) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (entry_valid_o) begin
			$display("at %0t: request queue did not drain", $time);
			timeouts++;
		end
		req_checker_i.final_check();

		total = req_checker_i.mismatch_count + req_checker_i.other_count + timeouts;
		$display("mismatches %0d, other errors %0d, timeouts %0d",
			req_checker_i.mismatch_count, req_checker_i.other_count, timeouts);
		if (total == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire
